//--- host_io_pkg.sv
// words arriving from the host link, as sampled on clk_sys
// key events are toggle-strobed, so a repeated word with the same strobe is no event
// download writes are single-cycle strobes with no wait handshake
// the download data word is little-endian; the region letter is in the low byte

package host_io_pkg;

	////////////////////////////////////////////////////////////////////////////
	// keyboard
	////////////////////////////////////////////////////////////////////////////

	// strobe flips on every new key event, in either direction
	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	////////////////////////////////////////////////////////////////////////////
	// ROM download
	////////////////////////////////////////////////////////////////////////////

	// high and low halves of a download word
	typedef struct packed {
		logic [7:0] hi_byte;
		logic [7:0] lo_byte;
	} dl_byte_pair_t;

	// one data word, read raw or as two bytes
	typedef union packed {
		logic [15:0]   raw_word;
		dl_byte_pair_t bytes;
	} dl_data_u;

	// active is a level for the whole download, wr pulses once per word
	typedef struct packed {
		logic        active;
		logic        wr;
		logic [5:0]  index;
		logic [24:0] addr;
		dl_data_u    data;
	} dl_write_t;

	// indices up to this value carry BIOS images
	localparam logic [5:0] DL_INDEX_BIOS_MAX = 6'h01;
	// cartridge image
	localparam logic [5:0] DL_INDEX_CART = 6'h04;

endpackage

//--- console_pkg.sv
// region codes and constants seen by the console side
// region codes match the console's region option: JP, US, EU
// scan codes are PS/2 set 2 make codes without the E0 prefix
// the default header address fits carts with the region string at 0x1F0

package console_pkg;

	////////////////////////////////////////////////////////////////////////////
	// region
	////////////////////////////////////////////////////////////////////////////

	// code 3 is unused
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// region hotkey event, valid for one cycle
	typedef struct packed {
		logic    valid;
		logic    pressed;
		region_t region;
	} key_region_evt_t;

	// header scan result, ready holds until the download ends
	typedef struct packed {
		logic    ready;
		region_t region;
	} hdr_result_t;

	////////////////////////////////////////////////////////////////////////////
	// keyboard scan codes
	////////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] KEY_F1    = 8'h05;
	localparam logic [7:0] KEY_F2    = 8'h06;
	localparam logic [7:0] KEY_F3    = 8'h04;
	localparam logic [7:0] KEY_ENTER = 8'h5A;
	localparam logic [7:0] KEY_ESC   = 8'h76;

	////////////////////////////////////////////////////////////////////////////
	// cartridge header
	////////////////////////////////////////////////////////////////////////////

	// ASCII 'J' and 'U', anything else reads as EU
	localparam logic [7:0] HDR_CHAR_J = 8'h4A;
	localparam logic [7:0] HDR_CHAR_U = 8'h55;

	// byte address of the region letter
	localparam logic [24:0] HDR_ADDR_DEFAULT = 25'h1F0;

endpackage

//--- hotkey_decoder.sv
// turns host key events into region hotkeys and the debug-menu chord
// F1/F2/F3 only count without the extended prefix; Enter matches keypad Enter too
// the chord needs both Enter and Escape held down; releasing either clears its half
// all outputs are registered, one cycle after the key word is sampled

module hotkey_decoder (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  host_io_pkg::ps2_key_t        key,
	output console_pkg::key_region_evt_t key_evt,
	output logic                         chord_toggle
);

	logic                 old_stb;
	logic                 new_evt;
	logic                 is_fkey;
	console_pkg::region_t fkey_region;
	logic                 enter_down;
	logic                 esc_down;
	logic                 enter_nxt;
	logic                 esc_nxt;
	logic                 chord_hit;
	logic                 evt_valid;
	logic                 evt_pressed;
	console_pkg::region_t evt_region;

	// any strobe flip is a fresh event
	assign new_evt = key.strobe ^ old_stb;

	// function keys to region
	always_comb begin
		is_fkey = 1'b0;
		fkey_region = console_pkg::REGION_JP;
		if (!key.extended) begin
			case (key.code)
				console_pkg::KEY_F1: begin
					is_fkey = 1'b1;
					fkey_region = console_pkg::REGION_JP;
				end
				console_pkg::KEY_F2: begin
					is_fkey = 1'b1;
					fkey_region = console_pkg::REGION_US;
				end
				console_pkg::KEY_F3: begin
					is_fkey = 1'b1;
					fkey_region = console_pkg::REGION_EU;
				end
				default: ;
			endcase
		end
	end

	// chord flags follow the key state
	always_comb begin
		enter_nxt = enter_down;
		esc_nxt = esc_down;
		if (new_evt) begin
			if (key.code == console_pkg::KEY_ENTER)
				enter_nxt = key.pressed;
			if (key.code == console_pkg::KEY_ESC)
				esc_nxt = key.pressed;
		end
	end

	assign chord_hit = enter_nxt & esc_nxt;

	always_ff @(posedge clk_sys) begin
		// tracking the strobe in reset avoids a false event on release
		old_stb <= key.strobe;
		if (reset) begin
			enter_down <= 1'b0;
			esc_down <= 1'b0;
			chord_toggle <= 1'b0;
			evt_valid <= 1'b0;
		end else begin
			evt_valid <= new_evt & is_fkey;
			chord_toggle <= chord_hit;
			// both halves seen, start over
			enter_down <= enter_nxt & ~chord_hit;
			esc_down <= esc_nxt & ~chord_hit;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (new_evt & is_fkey) begin
			evt_pressed <= key.pressed;
			evt_region <= fkey_region;
		end
	end

	assign key_evt = '{valid: evt_valid, pressed: evt_pressed, region: evt_region};

	// key events are far apart, so valid is a single-cycle pulse, and code 3 never leaves here
	a_evt_single: assert property (@(posedge clk_sys) disable iff (reset)
		key_evt.valid |-> (key_evt.region != 2'd3) ##1 !key_evt.valid)
		else $error("key_evt held or bad region");

endmodule

//--- cart_header_scanner.sv
// watches ROM downloads (BIOS or cartridge) for the header region letter
// HDR_ADDR is the byte address of the letter; it is taken from the low data byte
// ready holds from the header write until the download ends
// a new download clears ready on its first cycle unless that cycle writes the header

module cart_header_scanner #(
	parameter logic [24:0] HDR_ADDR = console_pkg::HDR_ADDR_DEFAULT
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  host_io_pkg::dl_write_t   dl,
	output console_pkg::hdr_result_t hdr
);

	logic                 rom_dl;
	logic                 old_rom_dl;
	logic                 dl_start;
	logic                 dl_end;
	logic                 hdr_wr;
	logic                 hdr_ready;
	console_pkg::region_t hdr_region;
	console_pkg::region_t letter_region;

	////////////////////////////////////////////////////////////////////////////
	// download classification
	////////////////////////////////////////////////////////////////////////////

	// BIOS images or a cartridge, nothing else
	assign rom_dl = dl.active &&
		((dl.index <= host_io_pkg::DL_INDEX_BIOS_MAX) ||
		 (dl.index == host_io_pkg::DL_INDEX_CART));

	assign dl_start = rom_dl & ~old_rom_dl;
	assign dl_end = ~rom_dl & old_rom_dl;

	assign hdr_wr = rom_dl && dl.wr && (dl.addr == HDR_ADDR);

	////////////////////////////////////////////////////////////////////////////
	// letter decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (dl.data.bytes.lo_byte)
			console_pkg::HDR_CHAR_J: letter_region = console_pkg::REGION_JP;
			console_pkg::HDR_CHAR_U: letter_region = console_pkg::REGION_US;
			default:                 letter_region = console_pkg::REGION_EU;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_rom_dl <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			old_rom_dl <= rom_dl;
			if (dl_start | dl_end)
				hdr_ready <= 1'b0;
			// header write wins over the start clear
			if (hdr_wr)
				hdr_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (hdr_wr)
			hdr_region <= letter_region;
	end

	assign hdr = '{ready: hdr_ready, region: hdr_region};

	// ready only lives inside a ROM download or on the cycle its end is seen
	a_ready_in_dl: assert property (@(posedge clk_sys) disable iff (reset)
		hdr.ready |-> (rom_dl || old_rom_dl))
		else $error("header ready outside ROM download");

endmodule

//--- region_arbiter.sv
// merges keyboard hotkeys and the cartridge header into the console region request
// region_set is a level; the console treats it as a reset request
// a header rise beats a key event on the same cycle
// a header fall clears region_set even if a key event arrives with it

module region_arbiter (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  console_pkg::key_region_evt_t key_evt,
	input  logic                         chord_toggle,
	input  console_pkg::hdr_result_t     hdr,
	output console_pkg::region_t         region_req,
	output logic                         region_set,
	output logic                         dbg_menu
);

	logic old_ready;
	logic hdr_rise;
	logic hdr_fall;

	////////////////////////////////////////////////////////////////////////////
	// header edges
	////////////////////////////////////////////////////////////////////////////

	assign hdr_rise = hdr.ready & ~old_ready;
	assign hdr_fall = ~hdr.ready & old_ready;

	always_ff @(posedge clk_sys) begin
		if (reset)
			old_ready <= 1'b0;
		else
			old_ready <= hdr.ready;
	end

	////////////////////////////////////////////////////////////////////////////
	// region request
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region_req <= console_pkg::REGION_JP;
			region_set <= 1'b0;
		end else begin
			if (hdr_rise) begin
				region_req <= hdr.region;
				region_set <= 1'b1;
			end else if (key_evt.valid) begin
				// key-down requests a reset, key-up releases it
				region_req <= key_evt.region;
				region_set <= key_evt.pressed;
			end
			// download over, release the console
			if (hdr_fall)
				region_set <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// debug menu
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			dbg_menu <= 1'b0;
		else if (chord_toggle)
			dbg_menu <= ~dbg_menu;
	end

	// region_set only rises after a hotkey or a header result
	a_set_cause: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(region_set) |-> $past(key_evt.valid || hdr_rise))
		else $error("region_set rose without a cause");

endmodule

//--- region_ctrl_top.sv
// region and debug-menu control for a console core
// key word to region outputs and header write to region_set take 2 cycles each
// HDR_ADDR moves the header letter for other cartridge formats
// no back-pressure: every key word and download write is taken as it arrives

module region_ctrl_top #(
	parameter logic [24:0] HDR_ADDR = console_pkg::HDR_ADDR_DEFAULT
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  host_io_pkg::ps2_key_t  key,
	input  host_io_pkg::dl_write_t dl,
	output console_pkg::region_t   region_req,
	output logic                   region_set,
	output logic                   dbg_menu
);

	console_pkg::key_region_evt_t key_evt;
	logic                         chord_toggle;
	console_pkg::hdr_result_t     hdr;

	// keyboard side
	hotkey_decoder hotkey_decoder_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.key          (key),
		.key_evt      (key_evt),
		.chord_toggle (chord_toggle)
	);

	// download side
	cart_header_scanner #(
		.HDR_ADDR (HDR_ADDR)
	) cart_header_scanner_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.hdr     (hdr)
	);

	// merge both into the console request
	region_arbiter region_arbiter_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.key_evt      (key_evt),
		.chord_toggle (chord_toggle),
		.hdr          (hdr),
		.region_req   (region_req),
		.region_set   (region_set),
		.dbg_menu     (dbg_menu)
	);

endmodule

//--- tb_region_ctrl.sv
// testbench for region_ctrl_top with the default header address
// every driven cycle goes through the reference model, outputs are compared 2 cycles later
// inputs hold between steps, so download writes are cleared after one cycle
// random scan codes, addresses and download lengths come from a fixed seed

module tb_region_ctrl;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [24:0] HDR_ADDR = console_pkg::HDR_ADDR_DEFAULT;
	// reset, then tests 1 to 6 as laid out in the main block
	localparam int TEST_CYCLES = 8 + 31 + 44 + 29 + 129 + 40 + 15;
	localparam int MAX_CYCLES = TEST_CYCLES + 64;

	// inputs held for one cycle, key_flip marks a new key event
	typedef struct packed {
		logic                   key_flip;
		logic                   pressed;
		logic                   extended;
		logic [7:0]             code;
		host_io_pkg::dl_write_t dl;
	} step_t;

	// visible outputs plus the state needed to predict them
	typedef struct packed {
		console_pkg::region_t region;
		logic                 set;
		logic                 dbg;
		logic                 enter_dn;
		logic                 esc_dn;
		logic                 rom_active;
		logic                 hdr_ready;
	} model_t;

	logic                   clk_sys;
	logic                   reset;
	host_io_pkg::ps2_key_t  key;
	host_io_pkg::dl_write_t dl;
	console_pkg::region_t   region_req;
	logic                   region_set;
	logic                   dbg_menu;

	step_t  cur;
	model_t model;
	model_t exp_now;
	model_t exp_q[$];
	int     due_q[$];
	logic   key_stb;
	int     cycles = 0;
	int     checks = 0;
	int     errors = 0;
	int     err_mark = 0;
	int     tests = 0;

	region_ctrl_top #(
		.HDR_ADDR (HDR_ADDR)
	) region_ctrl_top_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.key        (key),
		.dl         (dl),
		.region_req (region_req),
		.region_set (region_set),
		.dbg_menu   (dbg_menu)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model, one call per input cycle
	////////////////////////////////////////////////////////////////////////////

	function automatic model_t expected_outputs(input model_t m, input step_t s);
		model_t               n;
		logic                 rom;
		logic                 ready;
		logic                 fkey;
		console_pkg::region_t fkey_reg;
		console_pkg::region_t letter_reg;
		n = m;
		fkey = 1'b0;
		fkey_reg = console_pkg::REGION_JP;
		// header side
		rom = s.dl.active && ((s.dl.index <= host_io_pkg::DL_INDEX_BIOS_MAX) ||
			(s.dl.index == host_io_pkg::DL_INDEX_CART));
		ready = m.hdr_ready;
		if (rom != m.rom_active)
			ready = 1'b0;
		if (rom && s.dl.wr && (s.dl.addr == HDR_ADDR))
			ready = 1'b1;
		n.rom_active = rom;
		n.hdr_ready = ready;
		if (s.dl.data.bytes.lo_byte == "J")
			letter_reg = console_pkg::REGION_JP;
		else if (s.dl.data.bytes.lo_byte == "U")
			letter_reg = console_pkg::REGION_US;
		else
			letter_reg = console_pkg::REGION_EU;
		// region hotkeys
		if (s.key_flip && !s.extended) begin
			fkey = 1'b1;
			if (s.code == 8'h05)
				fkey_reg = console_pkg::REGION_JP;
			else if (s.code == 8'h06)
				fkey_reg = console_pkg::REGION_US;
			else if (s.code == 8'h04)
				fkey_reg = console_pkg::REGION_EU;
			else
				fkey = 1'b0;
		end
		// enter + escape chord
		if (s.key_flip && s.code == 8'h5A)
			n.enter_dn = s.pressed;
		if (s.key_flip && s.code == 8'h76)
			n.esc_dn = s.pressed;
		if (n.enter_dn && n.esc_dn) begin
			n.dbg = ~m.dbg;
			n.enter_dn = 1'b0;
			n.esc_dn = 1'b0;
		end
		// header rise first, then hotkey, header fall last
		if (ready && !m.hdr_ready) begin
			n.region = letter_reg;
			n.set = 1'b1;
		end else if (fkey) begin
			n.region = fkey_reg;
			n.set = s.pressed;
		end
		if (!ready && m.hdr_ready)
			n.set = 1'b0;
		return n;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_step(input step_t s);
		@(posedge clk_sys);
		if (s.key_flip)
			key_stb = ~key_stb;
		key <= '{strobe: key_stb, pressed: s.pressed, extended: s.extended, code: s.code};
		dl <= s.dl;
		model = expected_outputs(model, s);
		exp_q.push_back(model);
		due_q.push_back(cycles + 2);
	endtask

	task automatic idle(input int n);
		cur.key_flip = 1'b0;
		cur.dl.wr = 1'b0;
		repeat (n) drive_step(cur);
	endtask

	task automatic key_event(input logic [7:0] code, input logic pressed);
		cur.key_flip = 1'b1;
		cur.extended = 1'b0;
		cur.code = code;
		cur.pressed = pressed;
		drive_step(cur);
		idle(3);
	endtask

	task automatic start_download(input logic [5:0] index);
		cur.dl.active = 1'b1;
		cur.dl.index = index;
		idle(1);
	endtask

	task automatic end_download();
		cur.dl.active = 1'b0;
		idle(1);
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [7:0] lo);
		cur.dl.wr = 1'b1;
		cur.dl.addr = addr;
		// random high byte, the letter goes in the low byte
		cur.dl.data.raw_word = {8'($urandom), lo};
		drive_step(cur);
		cur.dl.wr = 1'b0;
	endtask

	function automatic logic [24:0] random_addr();
		logic [24:0] a;
		a = 25'($urandom);
		if (a == HDR_ADDR)
			a = a ^ 25'h2;
		return a;
	endfunction

	// up to 25 cycles including the tail after the end
	task automatic run_download(input logic [5:0] index, input logic hdr_write,
			input logic [7:0] letter);
		int n_before;
		int n_after;
		n_before = $urandom % 8 + 1;
		n_after = $urandom % 8 + 1;
		start_download(index);
		repeat (n_before) write_word(random_addr(), 8'($urandom));
		if (hdr_write)
			write_word(HDR_ADDR, letter);
		else
			write_word(random_addr(), letter);
		repeat (n_after) write_word(random_addr(), 8'($urandom));
		idle(3);
		end_download();
		idle(3);
	endtask

	function automatic logic is_hotkey(input logic [7:0] code);
		return code == 8'h05 || code == 8'h06 || code == 8'h04 ||
			code == 8'h5A || code == 8'h76;
	endfunction

	task automatic finish_test(input string name);
		idle(4);
		tests++;
		$display("test %s finished with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare and cycle limit
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		cycles <= cycles + 1;
		while (due_q.size() != 0 && due_q[0] == cycles) begin
			exp_now = exp_q.pop_front();
			void'(due_q.pop_front());
			checks++;
			assert (region_req === exp_now.region) else begin
				$display("ERR %0d ns region_req expected %0d got %0d", $time,
					exp_now.region, region_req);
				errors++;
			end
			assert (region_set === exp_now.set) else begin
				$display("ERR %0d ns region_set expected %0b got %0b", $time,
					exp_now.set, region_set);
				errors++;
			end
			assert (dbg_menu === exp_now.dbg) else begin
				$display("ERR %0d ns dbg_menu expected %0b got %0b", $time,
					exp_now.dbg, dbg_menu);
				errors++;
			end
		end
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles, the tests did not finish", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [7:0] letter;
		void'($urandom(22672));
		reset = 1'b1;
		key = '0;
		dl = '0;
		cur = '0;
		key_stb = 1'b0;
		model = '0;
		model.region = console_pkg::REGION_JP;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;

		// 1: function keys down and up, F1 last so its JP differs from EU
		idle(3);
		key_event(8'h06, 1'b1);
		key_event(8'h06, 1'b0);
		key_event(8'h04, 1'b1);
		key_event(8'h04, 1'b0);
		key_event(8'h05, 1'b1);
		key_event(8'h05, 1'b0);
		finish_test("function key regions");

		// 2: chord in both orders, then a lone enter
		key_event(8'h5A, 1'b1);
		key_event(8'h76, 1'b1);
		key_event(8'h5A, 1'b0);
		key_event(8'h76, 1'b0);
		key_event(8'h76, 1'b1);
		key_event(8'h5A, 1'b1);
		key_event(8'h76, 1'b0);
		key_event(8'h5A, 1'b0);
		key_event(8'h5A, 1'b1);
		key_event(8'h5A, 1'b0);
		finish_test("debug chord");

		// 3: cartridge with a US header
		run_download(host_io_pkg::DL_INDEX_CART, 1'b1, "U");
		finish_test("cartridge header US");

		// 4: letters, other address, index 2 is not a ROM image
		run_download(host_io_pkg::DL_INDEX_BIOS_MAX, 1'b1, "J");
		run_download(host_io_pkg::DL_INDEX_CART, 1'b1, "U");
		do
			letter = 8'h41 + 8'($urandom % 26);
		while (letter == "J" || letter == "U");
		run_download(host_io_pkg::DL_INDEX_CART, 1'b1, letter);
		run_download(host_io_pkg::DL_INDEX_CART, 1'b0, "J");
		run_download(6'h02, 1'b1, "J");
		finish_test("header letters");

		// 5: filler keys, then a changed word with the old strobe
		repeat (8) begin
			do
				letter = 8'($urandom);
			while (is_hotkey(letter));
			key_event(letter, 1'($urandom));
		end
		cur.code = 8'h06;
		cur.pressed = 1'b1;
		idle(4);
		finish_test("non-hotkey keys");

		// 6: F3 on the header rise cycle, header J must win
		start_download(host_io_pkg::DL_INDEX_CART);
		idle(2);
		cur.key_flip = 1'b1;
		cur.extended = 1'b0;
		cur.code = 8'h04;
		cur.pressed = 1'b1;
		write_word(HDR_ADDR, "J");
		idle(3);
		end_download();
		idle(3);
		finish_test("key and header together");

		// let the last expected values come due
		while (due_q.size() != 0)
			@(posedge clk_sys);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- list.f
host_io_pkg.sv
console_pkg.sv
hotkey_decoder.sv
cart_header_scanner.sv
region_arbiter.sv
region_ctrl_top.sv
tb_region_ctrl.sv
